//--- hw/neo_save_params.svh
// ================================================
// Save subsystem constants shared by the RTL
// Sector limits, store address widths, sector size
// Include wherever one of these values is needed
// ================================================

`ifndef NEO_SAVE_PARAMS_SVH
`define NEO_SAVE_PARAMS_SVH

// Host sector size in 16-bit words
`define NEO_SECTOR_WORDS 256

// Last sector on CD types, 8 kB of memory card
`define NEO_CD_LAST_SECTOR 15

// Last sector on cartridge types, 64 kB backup plus 2 kB card
`define NEO_CART_LAST_SECTOR 131

// Cartridge types keep the memory card from this sector up
`define NEO_MEMCARD_SECTOR 128

// Word address widths of the two stores
`define NEO_BACKUP_AW 15
`define NEO_MEMCARD_AW 12

`endif

//--- hw/neo_save_pkg.sv
// ================================================
// Types shared by the save subsystem
// Data and address vectors, system type, FSM states
// Import with a wildcard in the module header
// ================================================

package neo_save_pkg;

	`include "neo_save_params.svh"

	// Data paths
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;

	// Host side
	typedef logic [31:0] lba_t;
	typedef logic [$clog2(`NEO_SECTOR_WORDS)-1:0] buff_addr_t;
	typedef logic [63:0] img_size_t;

	// Store addresses, backup is word based and the card is byte based
	typedef logic [`NEO_BACKUP_AW-1:0]  backup_addr_t;
	typedef logic [`NEO_MEMCARD_AW:0]   card_addr_t;

	// Bit 1 set means a CD system
	typedef enum logic [1:0] {
		SYS_CONSOLE = 2'd0,
		SYS_ARCADE  = 2'd1,
		SYS_CD      = 2'd2,
		SYS_CDZ     = 2'd3
	} sys_type_t;

	// Save image transfer FSM
	typedef enum logic [1:0] {
		XFER_IDLE    = 2'd0,
		XFER_REQUEST = 2'd1,
		XFER_SECTOR  = 2'd2
	} xfer_state_t;

endpackage

//--- hw/save_sequencer.sv
// ================================================
// Save image transfer FSM
// Loads the image after a ROM download ends and
// writes it back on a save request, one host sector
// at a time, through the sd_rd/sd_wr/sd_ack levels
// ================================================

`include "neo_save_params.svh"

module save_sequencer
	import neo_save_pkg::*;
(
	input  logic      clk_sys,
	input  logic      nRESET,
	input  sys_type_t sys_type,
	input  logic      ioctl_download,
	input  logic      img_mounted,
	input  logic      img_readonly,
	input  img_size_t img_size,
	input  logic      save_req,
	input  logic      sd_ack,
	output logic      sd_rd,
	output logic      sd_wr,
	output logic      xfer_active,
	output lba_t      sd_lba
);

	xfer_state_t state;

	logic download_prev;
	logic save_req_prev;
	logic sd_ack_prev;
	logic xfer_ena;
	logic load_pending;
	logic save_pending;
	logic loading;

	logic download_start;
	logic download_end;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic ena_cond;
	logic start_xfer;
	logic is_cd;
	logic last_sector;

	// ================================================
	// Edge detection and transfer enable
	// ================================================

	assign download_start = ~download_prev & ioctl_download;
	assign download_end   = download_prev & ~ioctl_download;
	assign save_rise      = ~save_req_prev & save_req;
	assign ack_rise       = ~sd_ack_prev & sd_ack;
	assign ack_fall       = sd_ack_prev & ~sd_ack;

	// Mounted, non-empty, writable and no download running
	assign ena_cond = ~ioctl_download & img_mounted & (|img_size) & ~img_readonly;

	assign start_xfer = (state == XFER_IDLE) & xfer_ena & (load_pending | save_pending);

	// CD types only carry the memory card
	assign is_cd       = (sys_type == SYS_CD) || (sys_type == SYS_CDZ);
	assign last_sector = is_cd ? (sd_lba >= lba_t'(`NEO_CD_LAST_SECTOR))
		: (sd_lba >= lba_t'(`NEO_CART_LAST_SECTOR));

	assign xfer_active = (state != XFER_IDLE);

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			download_prev <= 1'b0;
			save_req_prev <= 1'b0;
			sd_ack_prev   <= 1'b0;
			xfer_ena      <= 1'b0;
			load_pending  <= 1'b0;
			save_pending  <= 1'b0;
		end
		else
		begin
			download_prev <= ioctl_download;
			save_req_prev <= save_req;
			sd_ack_prev   <= sd_ack;

			// A new download invalidates the mounted save
			if (download_start)
				xfer_ena <= 1'b0;
			else if (ena_cond)
				xfer_ena <= 1'b1;

			// Load waits here until transfers are allowed
			if (download_end)
				load_pending <= 1'b1;
			else if (start_xfer || download_start)
				load_pending <= 1'b0;

			// Save edges are dropped while busy or disabled
			if (save_rise)
				save_pending <= 1'b1;
			else if (start_xfer || (state != XFER_IDLE) || !xfer_ena)
				save_pending <= 1'b0;
		end
	end

	// ================================================
	// Sector loop
	// ================================================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state   <= XFER_IDLE;
			loading <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			sd_lba  <= '0;
		end
		else
		begin
			case (state)
				XFER_IDLE:
				begin
					// Load wins when both are pending
					if (start_xfer)
					begin
						state   <= XFER_REQUEST;
						loading <= load_pending;
						sd_lba  <= '0;
						sd_rd   <= load_pending;
						sd_wr   <= ~load_pending;
					end
				end
				XFER_REQUEST:
				begin
					// Host took the request, drop the level
					if (ack_rise)
					begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= XFER_SECTOR;
					end
				end
				XFER_SECTOR:
				begin
					// Sector finished on the host side
					if (ack_fall)
					begin
						if (last_sector)
							state <= XFER_IDLE;
						else
						begin
							sd_lba <= sd_lba + lba_t'(1);
							sd_rd  <= loading;
							sd_wr  <= ~loading;
							state  <= XFER_REQUEST;
						end
					end
				end
				default:
					state <= XFER_IDLE;
			endcase
		end
	end

	// Load and save requests are exclusive
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(sd_rd && sd_wr));

	// Sector number stays inside the save image
	a_lba_range: assert property (@(posedge clk_sys) disable iff (!nRESET)
		sd_lba <= lba_t'(`NEO_CART_LAST_SECTOR));

endmodule

//--- hw/save_store.sv
// ================================================
// Backup RAM and memory card behind the host buffer
// Host words go to one store by system type and
// sector number, CPU strobes are gated per system
// ================================================

`include "neo_save_params.svh"

module save_store
	import neo_save_pkg::*;
(
	input  logic         clk_sys,
	input  logic         nRESET,
	input  sys_type_t    sys_type,
	input  lba_t         sd_lba,
	input  logic         sd_ack,
	input  logic         sd_buff_wr,
	input  buff_addr_t   sd_buff_addr,
	input  word_t        sd_buff_dout,
	output word_t        sd_buff_din,
	input  backup_addr_t cpu_addr,
	input  card_addr_t   card_addr,
	input  word_t        cpu_wdata,
	input  logic         bram_we_lo,
	input  logic         bram_we_hi,
	input  logic         bram_unlock,
	input  logic         card_we,
	input  logic         card_unlock,
	output word_t        bram_rdata,
	output byte_t        card_rdata
);

	// Sector bits that index each store
	localparam int BRAM_LBA_W = `NEO_BACKUP_AW - $bits(buff_addr_t);
	localparam int CARD_LBA_W = `NEO_MEMCARD_AW - $bits(buff_addr_t);

	logic is_arcade;
	logic is_cd;
	logic card_sector;
	logic bram_host_we;
	logic card_host_we;

	backup_addr_t                bram_host_addr;
	logic [`NEO_MEMCARD_AW-1:0]  card_host_addr;

	word_t bram_host_rdata;
	word_t card_host_rdata;
	word_t bram_cpu_rdata;

	assign is_arcade = (sys_type == SYS_ARCADE);
	assign is_cd     = (sys_type == SYS_CD) || (sys_type == SYS_CDZ);

	// ================================================
	// Host side routing
	// ================================================

	// CD types put every sector in the card
	assign card_sector = is_cd | (sd_lba >= lba_t'(`NEO_MEMCARD_SECTOR));

	assign bram_host_addr = {sd_lba[BRAM_LBA_W-1:0], sd_buff_addr};
	assign card_host_addr = {sd_lba[CARD_LBA_W-1:0], sd_buff_addr};

	assign bram_host_we = is_arcade & ~card_sector & sd_buff_wr & sd_ack;
	assign card_host_we = card_sector & sd_buff_wr & sd_ack;

	// sd_lba is stable for the whole sector
	assign sd_buff_din = card_sector ? card_host_rdata : bram_host_rdata;

	// ================================================
	// CPU side
	// ================================================

	// Backup RAM only exists on arcade boards
	assign bram_rdata = is_arcade ? bram_cpu_rdata : '0;

	backup_ram u_backup_ram (
		.clk_sys    (clk_sys),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.we_lo      (bram_we_lo & bram_unlock & is_arcade),
		.we_hi      (bram_we_hi & bram_unlock & is_arcade),
		.cpu_rdata  (bram_cpu_rdata),
		.host_addr  (bram_host_addr),
		.host_wdata (sd_buff_dout),
		.host_we    (bram_host_we),
		.host_rdata (bram_host_rdata)
	);

	// Card is always writable on CD systems
	memcard_ram u_memcard_ram (
		.clk_sys    (clk_sys),
		.cpu_addr   (card_addr),
		.cpu_wdata  (cpu_wdata[7:0]),
		.cpu_we     (card_we & (is_cd | card_unlock)),
		.cpu_rdata  (card_rdata),
		.host_addr  (card_host_addr),
		.host_wdata (sd_buff_dout),
		.host_we    (card_host_we),
		.host_rdata (card_host_rdata)
	);

	// One host word lands in exactly one store
	a_host_we_excl: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(bram_host_we && card_host_we));

endmodule

//--- hw/backup_ram.sv
// ================================================
// 64 kB arcade backup RAM, 32k x 16
// CPU port writes bytes, host port writes words
// Both ports read back one clock after the address
// ================================================

module backup_ram
	import neo_save_pkg::*;
(
	input  logic         clk_sys,

	// CPU port
	input  backup_addr_t cpu_addr,
	input  word_t        cpu_wdata,
	input  logic         we_lo,
	input  logic         we_hi,
	output word_t        cpu_rdata,

	// Host buffer port
	input  backup_addr_t host_addr,
	input  word_t        host_wdata,
	input  logic         host_we,
	output word_t        host_rdata
);

	localparam int DEPTH = 2 ** $bits(backup_addr_t);

	word_t mem [DEPTH];

	always_ff @(posedge clk_sys)
	begin
		// Byte lanes from the CPU
		if (we_lo)
			mem[cpu_addr][7:0] <= cpu_wdata[7:0];
		if (we_hi)
			mem[cpu_addr][15:8] <= cpu_wdata[15:8];

		// Host word wins on an address clash
		if (host_we)
			mem[host_addr] <= host_wdata;

		// Old data on a same-cycle write
		cpu_rdata  <= mem[cpu_addr];
		host_rdata <= mem[host_addr];
	end

endmodule

//--- hw/memcard_ram.sv
// ================================================
// 8 kB memory card, 4k x 16 internally
// CPU sees bytes, the host buffer sees words
// Even byte address is the low byte of a word
// ================================================

`include "neo_save_params.svh"

module memcard_ram
	import neo_save_pkg::*;
(
	input  logic                       clk_sys,

	// CPU port, byte wide
	input  card_addr_t                 cpu_addr,
	input  byte_t                      cpu_wdata,
	input  logic                       cpu_we,
	output byte_t                      cpu_rdata,

	// Host buffer port, word wide
	input  logic [`NEO_MEMCARD_AW-1:0] host_addr,
	input  word_t                      host_wdata,
	input  logic                       host_we,
	output word_t                      host_rdata
);

	localparam int DEPTH = 2 ** `NEO_MEMCARD_AW;

	word_t mem [DEPTH];

	logic [`NEO_MEMCARD_AW-1:0] cpu_word;
	logic                       cpu_odd;

	assign cpu_word = cpu_addr[`NEO_MEMCARD_AW:1];
	assign cpu_odd  = cpu_addr[0];

	always_ff @(posedge clk_sys)
	begin
		// Odd bytes sit in the high lane
		if (cpu_we && cpu_odd)
			mem[cpu_word][15:8] <= cpu_wdata;
		if (cpu_we && !cpu_odd)
			mem[cpu_word][7:0] <= cpu_wdata;

		if (host_we)
			mem[host_addr] <= host_wdata;

		cpu_rdata  <= cpu_odd ? mem[cpu_word][15:8] : mem[cpu_word][7:0];
		host_rdata <= mem[host_addr];
	end

endmodule

//--- hw/neo_save_top.sv
// ================================================
// Save data subsystem top level
// Transfer FSM plus the two save stores, sharing
// the sector number on the host buffer side
// ================================================

module neo_save_top
	import neo_save_pkg::*;
(
	input  logic         clk_sys,
	input  logic         nRESET,
	input  sys_type_t    sys_type,

	// Host buffer
	input  logic         ioctl_download,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  img_size_t    img_size,
	input  logic         sd_ack,
	input  buff_addr_t   sd_buff_addr,
	input  word_t        sd_buff_dout,
	input  logic         sd_buff_wr,
	output logic         sd_rd,
	output logic         sd_wr,
	output lba_t         sd_lba,
	output word_t        sd_buff_din,

	// Control
	input  logic         save_req,
	output logic         xfer_active,

	// CPU strobes
	input  backup_addr_t cpu_addr,
	input  word_t        cpu_wdata,
	input  logic         bram_we_lo,
	input  logic         bram_we_hi,
	input  logic         bram_unlock,
	input  logic         card_we,
	input  logic         card_unlock,
	output word_t        bram_rdata,
	output byte_t        card_rdata
);

	// Card byte address is the low part of the CPU bus
	card_addr_t card_addr;

	assign card_addr = cpu_addr[$bits(card_addr_t)-1:0];

	save_sequencer u_save_sequencer (
		.clk_sys        (clk_sys),
		.nRESET         (nRESET),
		.sys_type       (sys_type),
		.ioctl_download (ioctl_download),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.save_req       (save_req),
		.sd_ack         (sd_ack),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.xfer_active    (xfer_active),
		.sd_lba         (sd_lba)
	);

	save_store u_save_store (
		.clk_sys      (clk_sys),
		.nRESET       (nRESET),
		.sys_type     (sys_type),
		.sd_lba       (sd_lba),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din),
		.cpu_addr     (cpu_addr),
		.card_addr    (card_addr),
		.cpu_wdata    (cpu_wdata),
		.bram_we_lo   (bram_we_lo),
		.bram_we_hi   (bram_we_hi),
		.bram_unlock  (bram_unlock),
		.card_we      (card_we),
		.card_unlock  (card_unlock),
		.bram_rdata   (bram_rdata),
		.card_rdata   (card_rdata)
	);

endmodule

//--- tb/sd_host_model.sv
// ==================================================
// Behavioral SD host buffer for the save subsystem
// Holds the save image, answers sector requests and
// keeps every word that a save writes back
// ==================================================

`include "neo_save_params.svh"

module sd_host_model
	import neo_save_pkg::*;
(
	input  logic       clk_sys,
	input  logic       sd_rd,
	input  logic       sd_wr,
	input  lba_t       sd_lba,
	input  word_t      sd_buff_din,
	output logic       sd_ack,
	output buff_addr_t sd_buff_addr,
	output word_t      sd_buff_dout,
	output logic       sd_buff_wr
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMG_WORDS = (`NEO_CART_LAST_SECTOR + 1) * `NEO_SECTOR_WORDS;

	// Image that loads read, filled by the testbench
	word_t img [IMG_WORDS];
	// Words captured during saves
	word_t saved [IMG_WORDS];

	// One sector, sd_ack held high for all of it
	task automatic serve_sector();
		int base;
		logic is_read;
		base = int'(sd_lba) * `NEO_SECTOR_WORDS;
		is_read = sd_rd;
		sd_ack = 1'b1;
		if (is_read)
		begin
			for (int i = 0; i < `NEO_SECTOR_WORDS; i++)
			begin
				@(posedge clk_sys);
				#10;
				sd_buff_addr = buff_addr_t'(i);
				sd_buff_dout = img[base + i];
				sd_buff_wr = 1'b1;
			end
			@(posedge clk_sys);
			#10;
			sd_buff_wr = 1'b0;
		end
		else
		begin
			// Read data shows up one clock after the address
			sd_buff_addr = '0;
			for (int i = 1; i <= `NEO_SECTOR_WORDS; i++)
			begin
				@(posedge clk_sys);
				#10;
				saved[base + i - 1] = sd_buff_din;
				if (i < `NEO_SECTOR_WORDS)
					sd_buff_addr = buff_addr_t'(i);
			end
		end
		sd_ack = 1'b0;
	endtask

	initial
	begin
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		for (int i = 0; i < IMG_WORDS; i++)
			saved[i] = '0;
		// Poll once per cycle after the design's outputs settle
		forever
		begin
			@(posedge clk_sys);
			#10;
			if ((sd_rd || sd_wr) && !sd_ack && (sd_lba <= lba_t'(`NEO_CART_LAST_SECTOR)))
				serve_sector();
		end
	end

endmodule

//--- tb/tb_neo_save.sv
// ==================================================
// Testbench for the save data subsystem
// Loads, saves, CD and console cases against a host
// model, with concurrent assertions doing the checks
// ==================================================

`include "neo_save_params.svh"

module tb_neo_save
	import neo_save_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMG_WORDS = (`NEO_CART_LAST_SECTOR + 1) * `NEO_SECTOR_WORDS;
	localparam int BRAM_WORDS = `NEO_MEMCARD_SECTOR * `NEO_SECTOR_WORDS;
	localparam int SAVE_ADDR = 'h1234;
	localparam logic [15:0] SAVE_WORD = 16'hbeef;

	logic clk_sys;
	logic nRESET;
	sys_type_t sys_type;
	logic ioctl_download;
	logic img_mounted;
	logic img_readonly;
	img_size_t img_size;
	logic sd_ack;
	buff_addr_t sd_buff_addr;
	word_t sd_buff_dout;
	logic sd_buff_wr;
	logic sd_rd;
	logic sd_wr;
	lba_t sd_lba;
	word_t sd_buff_din;
	logic save_req;
	logic xfer_active;
	backup_addr_t cpu_addr;
	word_t cpu_wdata;
	logic bram_we_lo;
	logic bram_we_hi;
	logic bram_unlock;
	logic card_we;
	logic card_unlock;
	word_t bram_rdata;
	byte_t card_rdata;

	// Check controls driven by the stimulus
	logic quiet;
	logic expect_rd;
	logic req_clear;
	logic req_prev;
	int req_count;
	logic chk_valid;
	int chk_id;
	logic [15:0] chk_got;
	logic [15:0] chk_exp;

	int errors;
	int timeouts;

	neo_save_top UUT (.*);

	sd_host_model u_host (
		.clk_sys      (clk_sys),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.sd_buff_din  (sd_buff_din),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr)
	);

	initial
		clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// Counts request rising edges of the running transfer
	always @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			req_prev <= 1'b0;
			req_count <= 0;
		end
		else
		begin
			req_prev <= sd_rd | sd_wr;
			if (req_clear)
				req_count <= 0;
			else if ((sd_rd | sd_wr) && !req_prev)
				req_count <= req_count + 1;
		end
	end

	// ==================================================
	// Checking assertions
	// ==================================================

	// No host traffic while nothing should start
	a_quiet: assert property (@(posedge clk_sys) disable iff (!nRESET)
		quiet |-> (!sd_rd && !sd_wr && !xfer_active))
	else
	begin
		errors++;
		$display("FAIL t=%0t unexpected request or transfer activity", $time);
	end

	// Sectors requested in order and in the expected direction
	a_req_order: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$rose(sd_rd || sd_wr) |-> ((sd_lba == lba_t'(req_count)) && (sd_rd == expect_rd)))
	else
	begin
		errors++;
		$display("FAIL t=%0t request lba %0d rd %0b, expected lba %0d rd %0b",
			$time, sd_lba, sd_rd, req_count, expect_rd);
	end

	a_value: assert property (@(posedge clk_sys) chk_valid |-> (chk_got == chk_exp))
	else
	begin
		errors++;
		$display("FAIL t=%0t check %0d got %h expected %h", $time, chk_id, chk_got, chk_exp);
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic compare(input int id, input logic [15:0] got, input logic [15:0] exp);
		chk_id = id;
		chk_got = got;
		chk_exp = exp;
		chk_valid = 1'b1;
		next_cycle();
		chk_valid = 1'b0;
	endtask

	task automatic apply_reset(input sys_type_t sys);
		nRESET = 1'b0;
		sys_type = sys;
		repeat (16)
			next_cycle();
		nRESET = 1'b1;
	endtask

	task automatic pulse_download();
		ioctl_download = 1'b1;
		repeat (4)
			next_cycle();
		ioctl_download = 1'b0;
	endtask

	// Waits for the start and then the end of one transfer
	task automatic wait_transfer(input int limit);
		int n;
		n = 0;
		while (!xfer_active && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (!xfer_active)
		begin
			timeouts++;
			$display("Timeout: transfer did not start within 20 cycles");
			return;
		end
		n = 0;
		while (xfer_active && n < limit)
		begin
			next_cycle();
			n++;
		end
		if (xfer_active)
		begin
			timeouts++;
			$display("Timeout: transfer still active after %0d cycles", limit);
		end
	endtask

	task automatic read_bram(input int addr, output word_t data);
		cpu_addr = backup_addr_t'(addr);
		next_cycle();
		data = bram_rdata;
	endtask

	task automatic read_card(input int addr, output byte_t data);
		cpu_addr = backup_addr_t'(addr);
		next_cycle();
		data = card_rdata;
	endtask

	task automatic write_card(input int addr, input byte_t data);
		cpu_addr = backup_addr_t'(addr);
		cpu_wdata = {8'h00, data};
		card_we = 1'b1;
		next_cycle();
		card_we = 1'b0;
	endtask

	// Image byte held by card byte b when card word 0 is image word base
	function automatic byte_t image_byte(input int base, input int b);
		word_t w;
		w = u_host.img[base + b / 2];
		return (b % 2 == 1) ? w[15:8] : w[7:0];
	endfunction

	// ==================================================
	// Test sequence
	// ==================================================

	task automatic run_tests();
		word_t w;
		byte_t b;
		word_t exp;

		// Idle after reset
		apply_reset(SYS_ARCADE);
		quiet = 1'b1;
		repeat (20)
			next_cycle();
		quiet = 1'b0;

		// Arcade load of all 132 sectors
		expect_rd = 1'b1;
		req_clear = 1'b1;
		next_cycle();
		req_clear = 1'b0;
		pulse_download();
		wait_transfer(100000);
		if (timeouts != 0)
			return;
		compare(1, 16'(req_count), 16'(`NEO_CART_LAST_SECTOR + 1));
		for (int i = 0; i < BRAM_WORDS; i++)
		begin
			read_bram(i, w);
			compare(2, w, u_host.img[i]);
		end
		for (int i = 0; i < 4 * 2 * `NEO_SECTOR_WORDS; i++)
		begin
			read_card(i, b);
			compare(3, {8'h00, b}, {8'h00, image_byte(BRAM_WORDS, i)});
		end

		// CPU write followed by a save round trip
		cpu_addr = backup_addr_t'(SAVE_ADDR);
		cpu_wdata = SAVE_WORD;
		bram_unlock = 1'b1;
		bram_we_lo = 1'b1;
		bram_we_hi = 1'b1;
		next_cycle();
		bram_we_lo = 1'b0;
		bram_we_hi = 1'b0;
		bram_unlock = 1'b0;
		expect_rd = 1'b0;
		req_clear = 1'b1;
		next_cycle();
		req_clear = 1'b0;
		save_req = 1'b1;
		wait_transfer(100000);
		save_req = 1'b0;
		if (timeouts != 0)
			return;
		compare(4, 16'(req_count), 16'(`NEO_CART_LAST_SECTOR + 1));
		for (int i = 0; i < IMG_WORDS; i++)
		begin
			exp = (i == SAVE_ADDR) ? SAVE_WORD : u_host.img[i];
			compare(5, u_host.saved[i], exp);
		end

		// CD load fills only the card
		apply_reset(SYS_CD);
		expect_rd = 1'b1;
		pulse_download();
		wait_transfer(20000);
		if (timeouts != 0)
			return;
		compare(6, 16'(req_count), 16'(`NEO_CD_LAST_SECTOR + 1));
		for (int i = 0; i < (`NEO_CD_LAST_SECTOR + 1) * 2 * `NEO_SECTOR_WORDS; i++)
		begin
			read_card(i, b);
			compare(7, {8'h00, b}, {8'h00, image_byte(0, i)});
		end
		write_card(5, ~image_byte(0, 5));
		read_card(5, b);
		compare(8, {8'h00, b}, {8'h00, ~image_byte(0, 5)});

		// Read-only image and then an unmounted one
		quiet = 1'b1;
		img_readonly = 1'b1;
		pulse_download();
		repeat (2000)
			next_cycle();
		img_readonly = 1'b0;
		img_mounted = 1'b0;
		pulse_download();
		repeat (2000)
			next_cycle();
		quiet = 1'b0;

		// Console type has no backup and a locked card
		apply_reset(SYS_CONSOLE);
		read_bram(SAVE_ADDR, w);
		compare(9, w, 16'h0000);
		write_card(10, ~image_byte(0, 10));
		read_card(10, b);
		compare(10, {8'h00, b}, {8'h00, image_byte(0, 10)});
	endtask

	task automatic finish_run();
		$display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	initial
	begin
		void'($urandom(32'h2cfc_dbae));
		nRESET = 1'b0;
		sys_type = SYS_ARCADE;
		ioctl_download = 1'b0;
		img_mounted = 1'b1;
		img_readonly = 1'b0;
		img_size = 64'd67584;
		save_req = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		bram_we_lo = 1'b0;
		bram_we_hi = 1'b0;
		bram_unlock = 1'b0;
		card_we = 1'b0;
		card_unlock = 1'b0;
		quiet = 1'b0;
		expect_rd = 1'b1;
		req_clear = 1'b0;
		chk_valid = 1'b0;
		chk_id = 0;
		chk_got = '0;
		chk_exp = '0;
		errors = 0;
		timeouts = 0;
		for (int i = 0; i < IMG_WORDS; i++)
			u_host.img[i] = word_t'($urandom);
		run_tests();
		finish_run();
	end

endmodule

//--- tb.f
+incdir+hw
hw/neo_save_pkg.sv
hw/save_sequencer.sv
hw/save_store.sv
hw/backup_ram.sv
hw/memcard_ram.sv
hw/neo_save_top.sv
tb/sd_host_model.sv
tb/tb_neo_save.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        ?= tb_neo_save
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
